// ==== project.f ====
+incdir+include
hw/execPkg.sv
hw/claAdder16.sv
hw/alu.sv
hw/branchCondition.sv
hw/execute.sv
hw/exMemLatch.sv
hw/exStage.sv
testbench/tbExStage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the exStage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f project.f --top-module tbExStage -o simExStage

out=$(./obj_dir/simExStage)
echo "$out"

if echo "$out" | grep -q "^No errors$"; then
   exit 0
fi
exit 1

// ==== testbench/exStage_testdata.txt ====
# op invA invB cin cond immSel pcSrcAlu setOp jalSel jumpReg slbiSel fwdA fwdB
# inA inB incPc imm8 imm11 | expected exResult exNextPc exLinkPc exAddr (all hex)
0 0 0 0 0 0 0 0 0 0 0 0 0 1234 0f0f 0100 00 000 2143 0100 0100 2143
0 0 1 1 0 0 0 0 0 0 0 0 0 1234 0f0f 0100 00 000 0325 0100 0100 0325
0 1 0 0 0 0 0 0 0 0 0 0 0 1234 0001 0100 00 000 edcc 0100 0100 edcc
1 0 0 0 0 0 0 0 0 0 0 0 0 f0f0 3c3c 0100 00 000 3030 0100 0100 3030
1 0 1 0 0 0 0 0 0 0 0 0 0 f0f0 3c3c 0100 00 000 c0c0 0100 0100 c0c0
2 0 0 0 0 0 0 0 0 0 0 0 0 f000 000f 0100 00 000 f00f 0100 0100 f00f
3 0 0 0 0 0 0 0 0 0 0 0 0 ffff 1234 0100 00 000 edcb 0100 0100 edcb
4 0 0 0 0 0 0 0 0 0 0 0 0 8001 0004 0100 00 000 0018 0100 0100 0018
4 1 0 0 0 0 0 0 0 0 0 0 0 fffe 0003 0100 00 000 0008 0100 0100 0008
5 0 0 0 0 0 0 0 0 0 0 0 0 1234 0004 0100 00 000 2340 0100 0100 2340
6 0 0 0 0 0 0 0 0 0 0 0 0 1234 0004 0100 00 000 4123 0100 0100 4123
7 0 0 0 0 0 0 0 0 0 0 0 0 8000 000f 0100 00 000 0001 0100 0100 0001
8 0 0 0 0 0 0 0 0 0 0 0 0 1234 0000 0100 00 000 2c48 0100 0100 2c48
9 0 0 0 0 0 0 0 0 0 0 0 0 00ab 12cd 0100 00 000 abcd 0100 0100 abcd
0 0 1 1 1 0 0 1 0 0 0 0 0 0005 0005 0100 00 000 0001 0100 0100 0000
0 0 1 1 2 0 0 1 0 0 0 0 0 0005 0005 0100 00 000 0000 0100 0100 0000
0 0 1 1 3 0 0 1 0 0 0 0 0 0003 0005 0100 00 000 0001 0100 0100 fffe
0 0 1 1 3 0 0 1 0 0 0 0 0 8000 0001 0100 00 000 0001 0100 0100 7fff
0 0 1 1 4 0 0 1 0 0 0 0 0 7fff ffff 0100 00 000 0001 0100 0100 8000
0 0 1 1 4 0 0 1 0 0 0 0 0 0003 0005 0100 00 000 0000 0100 0100 fffe
0 0 1 1 5 0 0 1 0 0 0 0 0 0005 0005 0100 00 000 0001 0100 0100 0000
0 0 1 1 5 0 0 1 0 0 0 0 0 0006 0005 0100 00 000 0000 0100 0100 0001
0 0 1 1 6 0 0 1 0 0 0 0 0 0005 0003 0100 00 000 0001 0100 0100 0002
0 0 1 1 6 0 0 1 0 0 0 0 0 0003 0005 0100 00 000 0000 0100 0100 fffe
0 0 1 1 0 0 0 1 0 0 0 0 0 0000 0000 0100 00 000 0000 0100 0100 0000
0 0 1 1 7 0 0 1 0 0 0 0 0 0001 0000 0100 00 000 0001 0100 0100 0001
0 0 1 1 1 0 0 0 0 0 0 0 0 0007 0007 0200 10 000 0000 0210 0210 0000
0 0 1 1 1 0 0 0 0 0 0 0 0 0007 0006 0200 10 000 0001 0200 0200 0001
0 0 1 1 1 0 0 0 0 0 0 0 0 0007 0007 0200 f0 000 0000 01f0 01f0 0000
0 0 1 1 7 1 0 0 0 0 0 0 0 0000 0000 0200 00 123 0000 0323 0323 0000
0 0 1 1 7 1 0 0 1 0 0 0 0 0000 0000 0200 00 7f0 0000 01f0 0200 0000
0 0 0 0 7 0 0 0 1 1 0 0 0 1000 0234 0200 00 000 1234 1234 0200 1234
0 0 0 0 7 0 1 0 0 0 0 0 0 3000 0000 0200 04 000 3000 3004 3004 3000
9 0 0 0 7 0 0 0 0 0 1 0 0 0012 0034 0200 10 000 1234 0200 0210 1234
0 0 0 0 0 0 0 0 0 0 0 8 0 0001 0002 0100 00 000 1a1c 0100 0100 1a1c
0 0 0 0 0 0 0 0 0 0 0 9 0 0001 0002 0100 00 000 2b2d 0100 0100 2b2d
0 0 0 0 0 0 0 0 0 0 0 a 0 0001 0002 0100 00 000 3c3e 0100 0100 3c3e
0 0 0 0 0 0 0 0 0 0 0 c 0 0001 0002 0100 00 000 4d4f 0100 0100 4d4f
0 0 0 0 0 0 0 0 0 0 0 d 0 0001 0002 0100 00 000 5e60 0100 0100 5e60
0 0 0 0 0 0 0 0 0 0 0 e 0 0001 0002 0100 00 000 6f71 0100 0100 6f71
0 0 0 0 0 0 0 0 0 0 0 0 8 0001 0002 0100 00 000 1a1b 0100 0100 1a1b
0 0 0 0 0 0 0 0 0 0 0 0 9 0001 0002 0100 00 000 2b2c 0100 0100 2b2c
0 0 0 0 0 0 0 0 0 0 0 0 a 0001 0002 0100 00 000 3c3d 0100 0100 3c3d
0 0 0 0 0 0 0 0 0 0 0 0 c 0001 0002 0100 00 000 4d4e 0100 0100 4d4e
0 0 0 0 0 0 0 0 0 0 0 0 d 0001 0002 0100 00 000 5e5f 0100 0100 5e5f
0 0 0 0 0 0 0 0 0 0 0 0 e 0001 0002 0100 00 000 6f70 0100 0100 6f70
0 0 0 0 0 0 0 0 0 0 0 3 6 0001 0002 0100 00 000 0003 0100 0100 0003

// ==== testbench/tbExStage.sv ====
/* testbench for the execute stage with its EX/MEM latch
   replays vectors from the data file with random stall cycles */
`timescale 1ns/1ps
`default_nettype none
`include "execute_settings.svh"

module tbExStage;

   import execPkg::*;

   localparam int W = `EX_WIDTH;
   // edge limit per vector including stalls
   localparam int TIMEOUT = 20;
   localparam int NCOL = 22;

   logic                    clk;
   logic                    rst;
   logic                    stall;
   logic                    inValid;
   logic [W-1:0]            incPc;
   logic [W-1:0]            inA;
   logic [W-1:0]            inB;
   logic [`EX_IMM8_W-1:0]   imm8;
   logic [`EX_IMM11_W-1:0]  imm11;
   logic [W-1:0]            x2xAlu;
   logic [W-1:0]            x2xImm8;
   logic [W-1:0]            x2xMem;
   logic [W-1:0]            m2xAlu;
   logic [W-1:0]            m2xImm8;
   logic [W-1:0]            m2xMem;
   logic [3:0]              fwdA;
   logic [3:0]              fwdB;
   aluOpT                   aluOp;
   logic                    invA;
   logic                    invB;
   logic                    cin;
   condT                    cond;
   logic                    immSel;
   logic                    pcSrcAlu;
   logic                    setOp;
   logic                    jalSel;
   logic                    jumpReg;
   logic                    slbiSel;
   logic                    exValid;
   logic [W-1:0]            exResult;
   logic [W-1:0]            exNextPc;
   logic [W-1:0]            exLinkPc;
   logic [W-1:0]            exAddr;

   int errors;
   int checks;
   int tests;
   // last captured item kept across stalled edges
   logic         prevValid;
   logic [W-1:0] prevRes;
   logic [W-1:0] prevNext;
   logic [W-1:0] prevLink;
   logic [W-1:0] prevAddr;
   // one parsed data line
   logic [W-1:0] col [0:NCOL-1];

   exStage i_exStage (
      .clk      (clk),
      .rst      (rst),
      .stall    (stall),
      .inValid  (inValid),
      .incPc    (incPc),
      .inA      (inA),
      .inB      (inB),
      .imm8     (imm8),
      .imm11    (imm11),
      .x2xAlu   (x2xAlu),
      .x2xImm8  (x2xImm8),
      .x2xMem   (x2xMem),
      .m2xAlu   (m2xAlu),
      .m2xImm8  (m2xImm8),
      .m2xMem   (m2xMem),
      .fwdA     (fwdA),
      .fwdB     (fwdB),
      .aluOp    (aluOp),
      .invA     (invA),
      .invB     (invB),
      .cin      (cin),
      .cond     (cond),
      .immSel   (immSel),
      .pcSrcAlu (pcSrcAlu),
      .setOp    (setOp),
      .jalSel   (jalSel),
      .jumpReg  (jumpReg),
      .slbiSel  (slbiSel),
      .exValid  (exValid),
      .exResult (exResult),
      .exNextPc (exNextPc),
      .exLinkPc (exLinkPc),
      .exAddr   (exAddr)
   );

   // 100 ns period
   always #50 clk = ~clk;

   task automatic checkValue(input string name, input logic [W-1:0] expected,
                             input logic [W-1:0] got);
      checks++;
      if (got !== expected) begin
         $display("ERROR %s expected %h got %h", name, expected, got);
         errors++;
      end
   endtask

   // registered outputs against one set of values
   task automatic checkOutputs(input logic vld, input logic [W-1:0] res,
                               input logic [W-1:0] nxt, input logic [W-1:0] lnk,
                               input logic [W-1:0] adr);
      checkValue("exValid", {{(W-1){1'b0}}, vld}, {{(W-1){1'b0}}, exValid});
      checkValue("exResult", res, exResult);
      checkValue("exNextPc", nxt, exNextPc);
      checkValue("exLinkPc", lnk, exLinkPc);
      checkValue("exAddr", adr, exAddr);
   endtask

   // column order follows the data file
   task automatic driveVector(input logic stallNow);
      aluOp    <= aluOpT'(col[0][3:0]);
      invA     <= col[1][0];
      invB     <= col[2][0];
      cin      <= col[3][0];
      cond     <= condT'(col[4][2:0]);
      immSel   <= col[5][0];
      pcSrcAlu <= col[6][0];
      setOp    <= col[7][0];
      jalSel   <= col[8][0];
      jumpReg  <= col[9][0];
      slbiSel  <= col[10][0];
      fwdA     <= col[11][3:0];
      fwdB     <= col[12][3:0];
      inA      <= col[13];
      inB      <= col[14];
      incPc    <= col[15];
      imm8     <= col[16][`EX_IMM8_W-1:0];
      imm11    <= col[17][`EX_IMM11_W-1:0];
      inValid  <= 1'b1;
      stall    <= stallNow;
   endtask

   // apply one vector and hold stall for some edges before the capture check
   task automatic runVector(input int holdCycles);
      int   edges;
      logic wasStalled;
      logic captured;
      int   errBefore;
      errBefore = errors;
      edges = 0;
      captured = 1'b0;
      @(posedge clk);
      driveVector(holdCycles > 0);
      while (!captured && edges < TIMEOUT) begin
         @(posedge clk);
         edges++;
         wasStalled = stall;
         if (edges >= holdCycles) begin
            stall <= 1'b0;
         end
         @(negedge clk);
         if (wasStalled) begin
            checkOutputs(prevValid, prevRes, prevNext, prevLink, prevAddr);
         end else begin
            captured = 1'b1;
            checkOutputs(1'b1, col[18], col[19], col[20], col[21]);
         end
      end
      if (!captured) begin
         $display("timeout: vector %0d was never captured by the latch", tests);
         errors++;
      end
      prevValid = 1'b1;
      prevRes = col[18];
      prevNext = col[19];
      prevLink = col[20];
      prevAddr = col[21];
      $display("test %0d stall %0d %s", tests, holdCycles,
               (errors == errBefore) ? "ok" : "failed");
   endtask

   initial begin
      int    fd;
      int    n;
      int    hold;
      string line;
      errors = 0;
      checks = 0;
      tests = 0;
      clk = 1'b0;
      rst = 1'b1;
      stall = 1'b0;
      // valid nonzero item presented while in reset
      inValid = 1'b1;
      incPc = 16'h0100;
      inA = 16'h1111;
      inB = 16'h2222;
      imm8 = '0;
      imm11 = '0;
      // distinct patterns so a wrong source shows up
      x2xAlu = 16'h1a1a;
      x2xImm8 = 16'h2b2b;
      x2xMem = 16'h3c3c;
      m2xAlu = 16'h4d4d;
      m2xImm8 = 16'h5e5e;
      m2xMem = 16'h6f6f;
      fwdA = '0;
      fwdB = '0;
      aluOp = OP_ADD;
      invA = 1'b0;
      invB = 1'b0;
      cin = 1'b0;
      cond = COND_NEVER;
      immSel = 1'b0;
      pcSrcAlu = 1'b0;
      setOp = 1'b0;
      jalSel = 1'b0;
      jumpReg = 1'b0;
      slbiSel = 1'b0;
      prevValid = 1'b0;
      prevRes = '0;
      prevNext = '0;
      prevLink = '0;
      prevAddr = '0;
      void'($urandom(83969));

      repeat (3) @(posedge clk);
      rst <= 1'b0;
      // first edge out of reset loads an all-zero invalid item
      inValid <= 1'b0;
      incPc <= '0;
      inA <= '0;
      inB <= '0;
      @(negedge clk);
      checkOutputs(1'b0, '0, '0, '0, '0);
      $display("reset check %s", (errors == 0) ? "ok" : "failed");

      fd = $fopen("testbench/exStage_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open the test data file");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
               continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                        col[15], col[16], col[17], col[18], col[19], col[20], col[21]);
            if (n != NCOL) begin
               $display("malformed data line: %s", line);
               errors++;
               continue;
            end
            // every fifth vector stalled plus some at random
            if (tests % 5 == 4 || $urandom % 6 == 0) begin
               hold = 1 + int'($urandom % 3);
            end else begin
               hold = 0;
            end
            runVector(hold);
            tests++;
         end
         $fclose(fd);
      end

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0 && tests > 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/exStage.sv ====
/* exStage: execute stage with its EX/MEM latch
   one clock from inputs to registered outputs */
`timescale 1ns/1ps
`default_nettype none
`include "execute_settings.svh"

module exStage (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   stall,
   input  logic                   inValid,
   input  logic [`EX_WIDTH-1:0]   incPc,
   input  logic [`EX_WIDTH-1:0]   inA,
   input  logic [`EX_WIDTH-1:0]   inB,
   input  logic [`EX_IMM8_W-1:0]  imm8,
   input  logic [`EX_IMM11_W-1:0] imm11,
   input  logic [`EX_WIDTH-1:0]   x2xAlu,
   input  logic [`EX_WIDTH-1:0]   x2xImm8,
   input  logic [`EX_WIDTH-1:0]   x2xMem,
   input  logic [`EX_WIDTH-1:0]   m2xAlu,
   input  logic [`EX_WIDTH-1:0]   m2xImm8,
   input  logic [`EX_WIDTH-1:0]   m2xMem,
   input  logic [3:0]             fwdA,
   input  logic [3:0]             fwdB,
   input  execPkg::aluOpT         aluOp,
   input  logic                   invA,
   input  logic                   invB,
   input  logic                   cin,
   input  execPkg::condT          cond,
   input  logic                   immSel,
   input  logic                   pcSrcAlu,
   input  logic                   setOp,
   input  logic                   jalSel,
   input  logic                   jumpReg,
   input  logic                   slbiSel,
   output logic                   exValid,
   output logic [`EX_WIDTH-1:0]   exResult,
   output logic [`EX_WIDTH-1:0]   exNextPc,
   output logic [`EX_WIDTH-1:0]   exLinkPc,
   output logic [`EX_WIDTH-1:0]   exAddr
);

   // combinational stage outputs into the latch
   logic [`EX_WIDTH-1:0] aluFinal;
   logic [`EX_WIDTH-1:0] newPc;
   logic [`EX_WIDTH-1:0] linkPc;
   logic [`EX_WIDTH-1:0] aluOut;

   execute i_execute (
      .incPc    (incPc),
      .inA      (inA),
      .inB      (inB),
      .imm8     (imm8),
      .imm11    (imm11),
      .x2xAlu   (x2xAlu),
      .x2xImm8  (x2xImm8),
      .x2xMem   (x2xMem),
      .m2xAlu   (m2xAlu),
      .m2xImm8  (m2xImm8),
      .m2xMem   (m2xMem),
      .fwdA     (fwdA),
      .fwdB     (fwdB),
      .aluOp    (aluOp),
      .invA     (invA),
      .invB     (invB),
      .cin      (cin),
      .cond     (cond),
      .immSel   (immSel),
      .pcSrcAlu (pcSrcAlu),
      .setOp    (setOp),
      .jalSel   (jalSel),
      .jumpReg  (jumpReg),
      .slbiSel  (slbiSel),
      .aluFinal (aluFinal),
      .newPc    (newPc),
      .linkPc   (linkPc),
      .aluOut   (aluOut)
   );

   exMemLatch i_exMemLatch (
      .clk      (clk),
      .rst      (rst),
      .stall    (stall),
      .inValid  (inValid),
      .aluFinal (aluFinal),
      .newPc    (newPc),
      .linkPc   (linkPc),
      .aluOut   (aluOut),
      .exValid  (exValid),
      .exResult (exResult),
      .exNextPc (exNextPc),
      .exLinkPc (exLinkPc),
      .exAddr   (exAddr)
   );

endmodule

`default_nettype wire

// ==== hw/exMemLatch.sv ====
/* exMemLatch: EX/MEM pipeline register
   loads every edge unless stalled, carries a valid bit */
`timescale 1ns/1ps
`default_nettype none
`include "execute_settings.svh"

module exMemLatch (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 stall,
   input  logic                 inValid,
   input  logic [`EX_WIDTH-1:0] aluFinal,
   input  logic [`EX_WIDTH-1:0] newPc,
   input  logic [`EX_WIDTH-1:0] linkPc,
   input  logic [`EX_WIDTH-1:0] aluOut,
   output logic                 exValid,
   output logic [`EX_WIDTH-1:0] exResult,
   output logic [`EX_WIDTH-1:0] exNextPc,
   output logic [`EX_WIDTH-1:0] exLinkPc,
   output logic [`EX_WIDTH-1:0] exAddr
);

   // stalled edge keeps the previous item
   always_ff @(posedge clk) begin
      if (rst) begin
         exValid  <= 1'b0;
         exResult <= '0;
         exNextPc <= '0;
         exLinkPc <= '0;
         exAddr   <= '0;
      end else if (!stall) begin
         exValid  <= inValid;
         exResult <= aluFinal;
         exNextPc <= newPc;
         exLinkPc <= linkPc;
         // raw ALU result doubles as memory address
         exAddr   <= aluOut;
      end
   end

   // a stall must freeze every output for the following cycle
   assert property (@(posedge clk) disable iff (rst)
      stall |=> ($stable(exValid) && $stable(exResult) && $stable(exNextPc) &&
                 $stable(exLinkPc) && $stable(exAddr)))
      else $error("exMemLatch: outputs changed across a stalled edge");

endmodule

`default_nettype wire

// ==== hw/execute.sv ====
/* execute: combinational EX stage, forwarding muxes, ALU, condition,
   branch target adder and next-PC / link / result selection */
`timescale 1ns/1ps
`default_nettype none
`include "execute_settings.svh"

module execute (
   input  logic [`EX_WIDTH-1:0]   incPc,
   input  logic [`EX_WIDTH-1:0]   inA,
   input  logic [`EX_WIDTH-1:0]   inB,
   input  logic [`EX_IMM8_W-1:0]  imm8,
   input  logic [`EX_IMM11_W-1:0] imm11,
   input  logic [`EX_WIDTH-1:0]   x2xAlu,
   input  logic [`EX_WIDTH-1:0]   x2xImm8,
   input  logic [`EX_WIDTH-1:0]   x2xMem,
   input  logic [`EX_WIDTH-1:0]   m2xAlu,
   input  logic [`EX_WIDTH-1:0]   m2xImm8,
   input  logic [`EX_WIDTH-1:0]   m2xMem,
   input  logic [3:0]             fwdA,
   input  logic [3:0]             fwdB,
   input  execPkg::aluOpT         aluOp,
   input  logic                   invA,
   input  logic                   invB,
   input  logic                   cin,
   input  execPkg::condT          cond,
   input  logic                   immSel,
   input  logic                   pcSrcAlu,
   input  logic                   setOp,
   input  logic                   jalSel,
   input  logic                   jumpReg,
   input  logic                   slbiSel,
   output logic [`EX_WIDTH-1:0]   aluFinal,
   output logic [`EX_WIDTH-1:0]   newPc,
   output logic [`EX_WIDTH-1:0]   linkPc,
   output logic [`EX_WIDTH-1:0]   aluOut
);

   import execPkg::*;

   localparam int W = `EX_WIDTH;

   logic [W-1:0] opA;
   logic [W-1:0] opB;
   logic         zeroFlag;
   logic         oflFlag;
   logic         carryFlag;
   logic         signFlag;
   logic         taken;
   logic [W-1:0] imm8Ext;
   logic [W-1:0] imm11Ext;
   logic [W-1:0] tgtBase;
   logic [W-1:0] tgtOffset;
   logic [W-1:0] target;
   logic [W-1:0] jmpPc;

   // bit 3 enable, bit 2 stage (0 EX/MEM, 1 MEM/WB), bits 1:0 source
   function automatic logic [W-1:0] pickOperand(input logic [3:0] ctrl,
                                                input logic [W-1:0] dflt);
      fwdSrcT       src;
      logic [W-1:0] fwdVal;
      src = fwdSrcT'(ctrl[1:0]);
      case (src)
         FWD_ALU:  fwdVal = ctrl[2] ? m2xAlu : x2xAlu;
         FWD_IMM8: fwdVal = ctrl[2] ? m2xImm8 : x2xImm8;
         FWD_MEM:  fwdVal = ctrl[2] ? m2xMem : x2xMem;
         default:  fwdVal = dflt;
      endcase
      return ctrl[3] ? fwdVal : dflt;
   endfunction

   assign opA = pickOperand(fwdA, inA);
   // B falls back to its own operand
   assign opB = pickOperand(fwdB, inB);

   alu i_alu (
      .inA    (opA),
      .inB    (opB),
      .cIn    (cin),
      .invA   (invA),
      .invB   (invB),
      .op     (aluOp),
      .result (aluOut),
      .zero   (zeroFlag),
      .ofl    (oflFlag),
      .carry  (carryFlag),
      .sign   (signFlag)
   );

   branchCondition i_branchCondition (
      .cond  (cond),
      .zero  (zeroFlag),
      .ofl   (oflFlag),
      .carry (carryFlag),
      .sign  (signFlag),
      .taken (taken)
   );

   // offsets are signed
   assign imm8Ext  = {{(W-`EX_IMM8_W){imm8[`EX_IMM8_W-1]}}, imm8};
   assign imm11Ext = {{(W-`EX_IMM11_W){imm11[`EX_IMM11_W-1]}}, imm11};

   assign tgtBase   = pcSrcAlu ? aluOut : incPc;
   assign tgtOffset = immSel ? imm11Ext : imm8Ext;

   // target only, flags not needed
   claAdder16 i_targetAdder (
      .a    (tgtBase),
      .b    (tgtOffset),
      .cIn  (1'b0),
      .sum  (target),
      .cOut (),
      .ofl  ()
   );

   assign jmpPc  = taken ? target : incPc;
   assign linkPc = jalSel ? incPc : jmpPc;
   // slbi wins, then register jump
   assign newPc  = slbiSel ? incPc : (jumpReg ? aluOut : jmpPc);

   assign aluFinal = setOp ? {{(W-1){1'b0}}, taken} : aluOut;

   // hazard unit must never enable a reserved source
   always_comb begin
      assert (!(fwdA[3] && (fwdA[1:0] == 2'b11)) && !(fwdB[3] && (fwdB[1:0] == 2'b11)))
         else $error("execute: enabled forwarding word with reserved source 2'b11");
   end

endmodule

`default_nettype wire

// ==== hw/branchCondition.sv ====
/* branchCondition: evaluates a branch or set condition
   from the ALU flags of a subtraction */
`timescale 1ns/1ps
`default_nettype none

module branchCondition (
   input  execPkg::condT cond,
   input  logic          zero,
   input  logic          ofl,
   input  logic          carry,
   input  logic          sign,
   output logic          taken
);

   import execPkg::*;

   // signed less-than of A - B
   logic lessThan;

   assign lessThan = sign ^ ofl;

   always_comb begin
      case (cond)
         COND_NEVER:  taken = 1'b0;
         COND_EQ:     taken = zero;
         COND_NE:     taken = ~zero;
         COND_LT:     taken = lessThan;
         COND_GE:     taken = ~lessThan;
         // LT or equal
         COND_LE:     taken = lessThan | zero;
         COND_CARRY:  taken = carry;
         COND_ALWAYS: taken = 1'b1;
         default:     taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
/* 16-bit ALU with add, logic, shift, rotate, bit-reverse and SLBI
   optional operand inversion, result plus zero/ofl/carry/sign flags */
`timescale 1ns/1ps
`default_nettype none
`include "execute_settings.svh"

module alu (
   input  logic [`EX_WIDTH-1:0] inA,
   input  logic [`EX_WIDTH-1:0] inB,
   input  logic                 cIn,
   input  logic                 invA,
   input  logic                 invB,
   input  execPkg::aluOpT       op,
   output logic [`EX_WIDTH-1:0] result,
   output logic                 zero,
   output logic                 ofl,
   output logic                 carry,
   output logic                 sign
);

   import execPkg::*;

   localparam int W = `EX_WIDTH;
   // 4-bit shift amount for 16 bits
   localparam int SHW = $clog2(W);

   // operands after optional inversion
   logic [W-1:0]   aIn;
   logic [W-1:0]   bIn;
   logic [W-1:0]   addSum;
   logic           addCout;
   logic           addOfl;
   logic [SHW-1:0] shAmt;
   // rotates taken from one half of A doubled up
   logic [2*W-1:0] rolWide;
   logic [2*W-1:0] rorWide;
   logic [W-1:0]   revA;

   assign aIn = invA ? ~inA : inA;
   assign bIn = invB ? ~inB : inB;

   // subtraction is invB plus cIn
   claAdder16 i_adder (
      .a    (aIn),
      .b    (bIn),
      .cIn  (cIn),
      .sum  (addSum),
      .cOut (addCout),
      .ofl  (addOfl)
   );

   assign shAmt   = bIn[SHW-1:0];
   assign rolWide = {aIn, aIn} << shAmt;
   assign rorWide = {aIn, aIn} >> shAmt;

   // msb to lsb swap
   always_comb begin
      for (int i = 0; i < W; i++) begin
         revA[i] = aIn[W-1-i];
      end
   end

   always_comb begin
      case (op)
         OP_ADD:  result = addSum;
         OP_AND:  result = aIn & bIn;
         OP_OR:   result = aIn | bIn;
         OP_XOR:  result = aIn ^ bIn;
         OP_ROL:  result = rolWide[2*W-1:W];
         OP_SLL:  result = aIn << shAmt;
         OP_ROR:  result = rorWide[W-1:0];
         OP_SRL:  result = aIn >> shAmt;
         OP_BTR:  result = revA;
         // low byte of B into the vacated byte
         OP_SLBI: result = {aIn[W-9:0], bIn[7:0]};
         default: result = '0;
      endcase
   end

   // carry and overflow only mean something for the adder
   assign carry = (op == OP_ADD) ? addCout : 1'b0;
   assign ofl   = (op == OP_ADD) ? addOfl : 1'b0;
   assign sign  = result[W-1];
   assign zero  = ~|result;

   // lookahead sum and carry against a plain add
   always_comb begin
      assert ((op != OP_ADD) ||
              ({carry, result} == ({1'b0, aIn} + {1'b0, bIn} + {{W{1'b0}}, cIn})))
         else $error("alu: adder sum or carry differs from a plain add");
   end

endmodule

`default_nettype wire

// ==== hw/claAdder16.sv ====
/* claAdder16: two-level carry-lookahead adder
   four 4-bit groups, carry-out and signed overflow */
`timescale 1ns/1ps
`default_nettype none
`include "execute_settings.svh"

module claAdder16 (
   input  logic [`EX_WIDTH-1:0] a,
   input  logic [`EX_WIDTH-1:0] b,
   input  logic                 cIn,
   output logic [`EX_WIDTH-1:0] sum,
   output logic                 cOut,
   output logic                 ofl
);

   localparam int W = `EX_WIDTH;
   // four groups of four bits
   localparam int NGRP = W / 4;

   // per-bit generate/propagate
   logic [W-1:0] g;
   logic [W-1:0] p;
   // carry into each bit
   logic [W-1:0] c;
   // group generate/propagate
   logic [NGRP-1:0] grpG;
   logic [NGRP-1:0] grpP;
   // carry into each group, top entry is the carry-out
   logic [NGRP:0] grpC;

   assign g = a & b;
   assign p = a ^ b;

   // first level: carries inside a group from its group carry-in
   for (genvar i = 0; i < NGRP; i++) begin : gGroup
      logic [3:0] gs;
      logic [3:0] ps;
      logic       ci;

      assign gs = g[4*i +: 4];
      assign ps = p[4*i +: 4];
      assign ci = grpC[i];

      assign c[4*i]   = ci;
      assign c[4*i+1] = gs[0] | (ps[0] & ci);
      assign c[4*i+2] = gs[1] | (ps[1] & gs[0]) | (ps[1] & ps[0] & ci);
      assign c[4*i+3] = gs[2] | (ps[2] & gs[1]) | (ps[2] & ps[1] & gs[0])
                      | (ps[2] & ps[1] & ps[0] & ci);

      // group terms, independent of carry-in
      assign grpG[i] = gs[3] | (ps[3] & gs[2]) | (ps[3] & ps[2] & gs[1])
                     | (ps[3] & ps[2] & ps[1] & gs[0]);
      assign grpP[i] = &ps;
   end

   // second level: group carries straight from cIn
   assign grpC[0] = cIn;
   assign grpC[1] = grpG[0] | (grpP[0] & cIn);
   assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & cIn);
   assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                  | (grpP[2] & grpP[1] & grpP[0] & cIn);
   assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (grpP[3] & grpP[2] & grpG[1])
                  | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                  | (grpP[3] & grpP[2] & grpP[1] & grpP[0] & cIn);

   assign sum  = p ^ c;
   assign cOut = grpC[NGRP];
   // signed overflow: carry into msb differs from carry out
   assign ofl  = c[W-1] ^ cOut;

endmodule

`default_nettype wire

// ==== hw/execPkg.sv ====
/* execute stage types
   ALU opcodes, branch/set conditions and forwarding sources */
`default_nettype none

package execPkg;

   // ALU operation select
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_AND  = 4'h1,
      OP_OR   = 4'h2,
      OP_XOR  = 4'h3,
      OP_ROL  = 4'h4,
      OP_SLL  = 4'h5,
      OP_ROR  = 4'h6,
      OP_SRL  = 4'h7,
      // bit reverse of A
      OP_BTR  = 4'h8,
      // A << 8 with low byte of B
      OP_SLBI = 4'h9
   } aluOpT;

   // branch or set condition, evaluated on ALU flags
   typedef enum logic [2:0] {
      COND_NEVER  = 3'd0,
      COND_EQ     = 3'd1,
      COND_NE     = 3'd2,
      COND_LT     = 3'd3,
      COND_GE     = 3'd4,
      COND_LE     = 3'd5,
      COND_CARRY  = 3'd6,
      COND_ALWAYS = 3'd7
   } condT;

   // source field of a forwarding word, 2'b11 reserved
   typedef enum logic [1:0] {
      FWD_ALU  = 2'b00,
      FWD_IMM8 = 2'b01,
      FWD_MEM  = 2'b10
   } fwdSrcT;

endpackage

`default_nettype wire

// ==== include/execute_settings.svh ====
/* execute stage settings
   datapath width and offset field widths before sign extension */
`ifndef EXECUTE_SETTINGS_SVH
`define EXECUTE_SETTINGS_SVH

// datapath width, also the PC width
`define EX_WIDTH 16

// short offset field, branches
`define EX_IMM8_W 8

// long offset field, jumps
`define EX_IMM11_W 11

`endif
